// ==== verilog.f ====
+incdir+.
dino_pkg.sv
obstacle_gen.sv
field_scroll.sv
dino_ctrl.sv
score_counter.sv
display_drive.sv
little_dinosaur.sv
tb_little_dinosaur.sv

// ==== tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

    // reference state advanced once per clock
    logic [32:1] m_lfsr;
    int          m_gap;
    logic [7:0]  m_new_col;
    logic [7:0]  m_field [0:dino_pkg::FIELD_COLS-1];    // 0 nearest the dinosaur
    int          m_height;
    int          m_life;
    logic [15:0] m_score;
    int          m_pre;
    int          m_row;
    logic [23:0] m_matrix;    // row select, col1, col2

    // active low codes with segment g first
    localparam logic [6:0] SEG_CODES [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

    task automatic reset_model();
        m_lfsr    = dino_pkg::LFSR_SEED;
        m_gap     = 0;
        m_new_col = 8'h00;
        m_height  = 0;
        m_life    = dino_pkg::LIFE_INIT;
        m_score   = 16'h0000;
        m_pre     = 0;
        m_row     = 0;
        m_matrix  = {8'hff, 16'h0000};
        for (int c = 0; c < dino_pkg::FIELD_COLS; c++)
            m_field[c] = 8'h00;
    endtask

    task automatic advance_model(input logic stop, input logic up, input logic down);
        logic       step;
        logic       hit;
        logic       fb;
        int         rb;
        logic [7:0] c1;
        logic [7:0] c2;
        step = !stop && (m_life != 0);
        rb   = dino_pkg::FIELD_ROWS - 1 - m_row;    // top matrix row shows field row 7
        for (int c = 0; c < 8; c++)
        begin
            c1[c] = m_field[c][rb];
            c2[c] = m_field[c + 8][rb];
        end
        if (rb >= m_height && rb < m_height + dino_pkg::DINO_TALL)
            c1[dino_pkg::DINO_COL] = 1'b1;
        m_matrix = {~(8'd1 << rb), c1, c2};
        m_row    = (m_row + 1) % 8;
        if (step)
        begin
            hit = 1'b0;
            for (int r = 0; r < dino_pkg::DINO_TALL; r++)
                if (m_height + r < 8 && m_field[dino_pkg::DINO_COL][m_height + r])
                    hit = 1'b1;
            for (int c = 0; c < dino_pkg::FIELD_COLS - 1; c++)
                m_field[c] = m_field[c + 1];
            m_field[dino_pkg::FIELD_COLS - 1] = m_new_col;
            if (m_gap == dino_pkg::GAP_LEN - 1)
                m_new_col = dino_pkg::OBSTACLE_PATTERNS[m_lfsr[3:1]];
            else
                m_new_col = 8'h00;
            m_gap  = (m_gap + 1) % dino_pkg::GAP_LEN;
            fb     = ~(m_lfsr[32] ^ m_lfsr[22] ^ m_lfsr[2] ^ m_lfsr[1]);
            m_lfsr = {m_lfsr[31:1], fb};
            if (up)
            begin
                if (m_height < dino_pkg::HEIGHT_MAX)
                    m_height++;
            end
            else if (down && m_height > 0)
                m_height--;
            if (hit)
                m_life--;
            if (m_pre == dino_pkg::SCORE_DIV - 1)
            begin
                m_pre = 0;
                m_score++;    // wraps at ffff
            end
            else
                m_pre++;
        end
    endtask

    function automatic logic [27:0] expected_ssd();
        return {SEG_CODES[m_score[15:12]], SEG_CODES[m_score[11:8]],
                SEG_CODES[m_score[7:4]], SEG_CODES[m_score[3:0]]};
    endfunction

`endif

// ==== tb_little_dinosaur.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_little_dinosaur;

    typedef struct packed {
        logic [15:0] cycles;
        logic        stop;
        logic        up;
        logic        down;
        logic        rnd;    // buttons drawn at random
    } entry_t;

    localparam int N_ENTRIES         = 6;
    localparam int SCAN_TIMEOUT      = 8;
    localparam int GAME_OVER_TIMEOUT = 400;

    logic              unit_clk;
    logic              restart;
    logic              stop;
    logic              up;
    logic              down;
    dino_pkg::matrix_t o_matrix;
    logic [3:0][6:0]   o_ssd;
    logic [2:0]        o_life;

    entry_t stim_table [0:N_ENTRIES-1];
    integer seed;

    `include "tb_model.svh"

    little_dinosaur dut (
        .i_unit_clk (unit_clk),
        .i_restart  (restart),
        .i_stop     (stop),
        .i_up       (up),
        .i_down     (down),
        .o_matrix   (o_matrix),
        .o_ssd      (o_ssd),
        .o_life     (o_life)
    );

    always #2 unit_clk = ~unit_clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    // inputs change on the falling edge and outputs are checked one edge later
    task automatic run_cycle(input logic s, input logic u, input logic d);
        stop = s;
        up   = u;
        down = d;
        @(posedge unit_clk);
        advance_model(s, u, d);
        @(negedge unit_clk);
        check_value("o_matrix", o_matrix, m_matrix);
        check_value("o_life", o_life, m_life);
    endtask

    initial
    begin
        int          waited;
        logic        u;
        logic        d;
        logic [31:0] rnd;
        unit_clk = 1'b0;
        restart  = 1'b0;
        stop     = 1'b0;
        up       = 1'b0;
        down     = 1'b0;
        seed     = 32'hf577;
        stim_table[0] = '{16'd40, 1'b0, 1'b1, 1'b0, 1'b0};     // climb to the top
        stim_table[1] = '{16'd300, 1'b0, 1'b1, 1'b0, 1'b0};
        stim_table[2] = '{16'd20, 1'b1, 1'b0, 1'b0, 1'b0};     // paused
        stim_table[3] = '{16'd120, 1'b0, 1'b0, 1'b0, 1'b1};
        stim_table[4] = '{16'd12, 1'b1, 1'b1, 1'b0, 1'b0};
        stim_table[5] = '{16'd60, 1'b0, 1'b0, 1'b1, 1'b0};     // drop into the obstacles
        reset_model();
        repeat (3) @(negedge unit_clk);
        check_value("o_life", o_life, dino_pkg::LIFE_INIT);
        check_value("o_ssd", o_ssd, {4{SEG_CODES[0]}});
        check_value("o_matrix.row_n", o_matrix.row_n, 8'hff);
        restart = 1'b1;

        waited = 0;
        while (o_matrix.row_n == 8'hff && waited < SCAN_TIMEOUT)
        begin
            run_cycle(1'b0, 1'b0, 1'b0);
            waited++;
        end
        if (o_matrix.row_n == 8'hff)
            report_timeout("row scan did not start after reset");

        for (int i = 0; i < N_ENTRIES; i++)
        begin
            for (int n = 0; n < stim_table[i].cycles; n++)
            begin
                u = stim_table[i].up;
                d = stim_table[i].down;
                if (stim_table[i].rnd)
                begin
                    rnd = $random(seed);
                    u   = rnd[0];
                    d   = rnd[1];
                end
                run_cycle(stim_table[i].stop, u, d);
            end
            check_value("o_ssd", o_ssd, expected_ssd());
        end

        waited = 0;
        while (o_life != 3'd0 && waited < GAME_OVER_TIMEOUT)
        begin
            run_cycle(1'b0, 1'b0, 1'b1);
            waited++;
        end
        if (o_life != 3'd0)
            report_timeout("lives never reached zero with the dinosaur held low");
        else
        begin
            // nothing moves after game over even with stop low
            repeat (50) run_cycle(1'b0, 1'b1, 1'b0);
            check_value("o_ssd", o_ssd, expected_ssd());
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== little_dinosaur.sv ====
`timescale 1ns/1ps
`default_nettype none

module little_dinosaur (
    input  wire logic           i_unit_clk,
    input  wire logic           i_restart,
    input  wire logic           i_stop,
    input  wire logic           i_up,
    input  wire logic           i_down,
    output dino_pkg::matrix_t   o_matrix,
    output logic [3:0][6:0]     o_ssd,
    output logic [2:0]          o_life
);

    logic              step;
    dino_pkg::col_t    new_col;
    dino_pkg::field_t  field;
    logic [2:0]        height;
    dino_pkg::score_t  score;

    obstacle_gen u_obstacle_gen (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_step     (step),
        .o_new_col  (new_col)
    );

    field_scroll u_field_scroll (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_step     (step),
        .i_new_col  (new_col),
        .o_field    (field)
    );

    dino_ctrl u_dino_ctrl (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_stop     (i_stop),
        .i_up       (i_up),
        .i_down     (i_down),
        .i_field    (field),
        .o_step     (step),
        .o_height   (height),
        .o_life     (o_life)
    );

    score_counter u_score_counter (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_step     (step),
        .o_score    (score)
    );

    display_drive u_display_drive (
        .i_unit_clk (i_unit_clk),
        .i_restart  (i_restart),
        .i_field    (field),
        .i_height   (height),
        .i_score    (score),
        .o_matrix   (o_matrix),
        .o_ssd      (o_ssd)
    );

endmodule

`default_nettype wire

// ==== display_drive.sv ====
`timescale 1ns/1ps
`default_nettype none

module display_drive (
    input  wire logic             i_unit_clk,
    input  wire logic             i_restart,
    input  wire dino_pkg::field_t i_field,
    input  wire logic [2:0]       i_height,
    input  wire dino_pkg::score_t i_score,
    output dino_pkg::matrix_t     o_matrix,
    output logic [3:0][6:0]       o_ssd
);

    logic [2:0]     row_idx;
    logic [2:0]     row_bit;    // field row shown on the selected matrix row
    dino_pkg::col_t body;
    logic [7:0]     col1_bits;
    logic [7:0]     col2_bits;

    // matrix row 0 is the top and field row 0 the bottom
    assign row_bit = 3'(dino_pkg::FIELD_ROWS - 1) - row_idx;
    assign body    = dino_pkg::dino_cells(i_height);

    always_comb
    begin
        for (int c = 0; c < 8; c++)
        begin
            col1_bits[c] = i_field[c][row_bit];
            col2_bits[c] = i_field[c + 8][row_bit];
        end
        // sprite drawn over matrix 1 only
        col1_bits[dino_pkg::DINO_COL] = col1_bits[dino_pkg::DINO_COL] | body[row_bit];
    end

    // scan never stops even when paused
    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            row_idx        <= '0;
            o_matrix.row_n <= '1;
            o_matrix.col1  <= '0;
            o_matrix.col2  <= '0;
        end
        else
        begin
            row_idx        <= row_idx + 3'd1;
            o_matrix.row_n <= ~(8'd1 << row_bit);
            o_matrix.col1  <= col1_bits;
            o_matrix.col2  <= col2_bits;
        end
    end

    // active low segments with g first
    function automatic logic [6:0] seg7(input logic [3:0] digit);
        case (digit)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;    // f
        endcase
    endfunction

    assign o_ssd[0] = seg7(i_score.d0);
    assign o_ssd[1] = seg7(i_score.d1);
    assign o_ssd[2] = seg7(i_score.d2);
    assign o_ssd[3] = seg7(i_score.d3);

endmodule

`default_nettype wire

// ==== score_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_counter (
    input  wire logic           i_unit_clk,
    input  wire logic           i_restart,
    input  wire logic           i_step,
    output dino_pkg::score_t    o_score
);

    logic [$clog2(dino_pkg::SCORE_DIV)-1:0] prescale;
    logic        tick;
    logic [15:0] score_next;

    assign tick = (prescale == dino_pkg::SCORE_DIV - 1);

    // carries ripple across the hex digits, ffff wraps to 0000
    assign score_next = o_score + 16'd1;

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            prescale <= '0;
        end
        else if (i_step)
        begin
            if (tick)
                prescale <= '0;
            else
                prescale <= prescale + 1'b1;
        end
    end

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            o_score <= '0;
        end
        else if (i_step && tick)
        begin
            o_score <= dino_pkg::score_t'(score_next);
        end
    end

endmodule

`default_nettype wire

// ==== dino_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dino_ctrl (
    input  wire logic             i_unit_clk,
    input  wire logic             i_restart,
    input  wire logic             i_stop,
    input  wire logic             i_up,
    input  wire logic             i_down,
    input  wire dino_pkg::field_t i_field,
    output logic                  o_step,
    output logic [2:0]            o_height,
    output logic [2:0]            o_life
);

    dino_pkg::col_t body;
    logic           hit;

    // game runs while not paused and lives remain
    assign o_step = !i_stop && (o_life != 3'd0);

    // compare against the column under the dinosaur before it moves
    assign body = dino_pkg::dino_cells(o_height);
    assign hit  = |(i_field[dino_pkg::DINO_COL] & body);

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            o_height <= '0;
        end
        else if (o_step)
        begin
            if (i_up)
            begin
                if (o_height != 3'(dino_pkg::HEIGHT_MAX))
                    o_height <= o_height + 3'd1;
            end
            else if (i_down)
            begin
                if (o_height != 3'd0)
                    o_height <= o_height - 3'd1;
            end
        end
    end

    // up wins when both buttons are held

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            o_life <= 3'(dino_pkg::LIFE_INIT);
        end
        else if (o_step && hit)
        begin
            o_life <= o_life - 3'd1;    // step needs a life so never below zero
        end
    end

endmodule

`default_nettype wire

// ==== field_scroll.sv ====
`timescale 1ns/1ps
`default_nettype none

module field_scroll (
    input  wire logic           i_unit_clk,
    input  wire logic           i_restart,
    input  wire logic           i_step,
    input  wire dino_pkg::col_t i_new_col,
    output dino_pkg::field_t    o_field
);

    dino_pkg::field_t field_next;

    // everything moves one column toward the dinosaur
    always_comb
    begin
        for (int c = 0; c < dino_pkg::FIELD_COLS - 1; c++)
        begin
            field_next[c] = o_field[c + 1];
        end
        field_next[dino_pkg::FIELD_COLS - 1] = i_new_col;    // enters at the far edge
    end

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            o_field <= '0;
        end
        else if (i_step)
        begin
            o_field <= field_next;
        end
    end

endmodule

`default_nettype wire

// ==== obstacle_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module obstacle_gen (
    input  wire logic           i_unit_clk,
    input  wire logic           i_restart,
    input  wire logic           i_step,
    output dino_pkg::col_t      o_new_col
);

    logic [32:1] lfsr;    // numbered from 1 like the tap list
    logic        feedback;
    logic [$clog2(dino_pkg::GAP_LEN)-1:0] gap_cnt;
    logic        spawn;

    // taps 32, 22, 2, 1
    assign feedback = lfsr[32] ~^ lfsr[22] ~^ lfsr[2] ~^ lfsr[1];

    assign spawn = (gap_cnt == dino_pkg::GAP_LEN - 1);

    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            lfsr    <= dino_pkg::LFSR_SEED;
            gap_cnt <= '0;
        end
        else if (i_step)
        begin
            lfsr <= {lfsr[31:1], feedback};
            if (spawn)
                gap_cnt <= '0;
            else
                gap_cnt <= gap_cnt + 1'b1;
        end
    end

    // empty columns between obstacles keep them apart
    always_ff @(posedge i_unit_clk or negedge i_restart)
    begin
        if (!i_restart)
        begin
            o_new_col <= '0;
        end
        else if (i_step)
        begin
            if (spawn)
                o_new_col <= dino_pkg::OBSTACLE_PATTERNS[lfsr[3:1]];
            else
                o_new_col <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== dino_pkg.sv ====
`default_nettype none

package dino_pkg;

    localparam int FIELD_ROWS = 8;
    localparam int FIELD_COLS = 16;    // 0..7 on matrix 1, 8..15 on matrix 2
    localparam int GAP_LEN    = 4;     // steps between obstacle columns
    localparam int DINO_COL   = 1;
    localparam int DINO_TALL  = 2;
    localparam int HEIGHT_MAX = 6;     // highest bottom row of the sprite
    localparam int LIFE_INIT  = 3;
    localparam int SCORE_DIV  = 16;

    localparam logic [31:0] LFSR_SEED = 32'h1;

    // one field column, bit r is row r, row 0 at the bottom
    typedef logic [FIELD_ROWS-1:0] col_t;

    // index 0 is the column nearest the dinosaur
    typedef col_t [FIELD_COLS-1:0] field_t;

    typedef struct packed {
        logic [3:0] d3;
        logic [3:0] d2;
        logic [3:0] d1;
        logic [3:0] d0;
    } score_t;

    typedef struct packed {
        logic [7:0] row_n;    // active low
        col_t       col1;
        col_t       col2;
    } matrix_t;

    // picked by the low three lfsr bits
    localparam col_t OBSTACLE_PATTERNS [0:7] = '{
        8'h07, 8'h0f, 8'h03, 8'h07,
        8'h09, 8'h0e, 8'h0b, 8'h00
    };

    // rows taken by the dinosaur standing at the given height
    function automatic col_t dino_cells(input logic [2:0] height);
        return col_t'(((1 << DINO_TALL) - 1) << height);
    endfunction

endpackage

`default_nettype wire
